/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_rx_link

out=$(./obj_dir/Vtb_rx_link)
echo "$out"
echo "$out" | grep -q "Done: no errors"

/* tb.f */
+incdir+verilog
verilog/rx_link_pkg.sv
verilog/rx_frame_parser.sv
verilog/rx_data_fifo.sv
verilog/rx_wr_cmd.sv
verilog/rx_loss_detect.sv
verilog/rx_link_top.sv
verif/tb_rx_link.sv

/* verif/rx_link_stim.txt */
# I k_msb k_lsb data step count rx_start base link_ena sync_ena dma_ready (hex, one record per count cycles)
# X D start step count | X C addr bbt | X F file_end channel type line len cks_err | X L link sync irq
I 0 0 0000 0 1 1 40000000 1 1 1
I 0 0 1234 1 4 0 40000000 1 1 1
I 0 0 EB90 0 1 0 40000000 1 1 1
I 0 0 E116 0 1 0 40000000 1 1 1
I 0 1 C5BC 0 1 0 40000000 1 1 1
I 0 0 5CFB 0 2 0 40000000 1 1 1
X F 0 1 2 000001 0372 0
X C 40000000 0378
X D 0100 1 1B9
I 1 1 5CFB 0 1 0 40000000 1 1 1
I 0 0 EB90 0 1 0 40000000 1 1 1
I 0 0 E116 0 1 0 40000000 1 1 1
I 0 0 1200 0 1 0 40000000 1 1 1
I 0 0 0001 0 1 0 40000000 1 1 1
I 0 0 0372 0 1 0 40000000 1 1 1
I 0 0 0100 1 C8 0 40000000 1 1 0
I 0 0 01C8 1 F1 0 40000000 1 1 1
I 0 0 496F 0 1 0 40000000 1 1 1
I 0 0 0000 0 2 0 40000000 1 1 1
X F 1 2 3 000002 0010 0
X C 40000378 0010
X D A000 1 8
I 0 1 C5BC 0 1 0 40000000 1 1 1
I 1 1 5CFB 0 1 0 40000000 1 1 1
I 0 0 EB90 0 1 0 40000000 1 1 1
I 0 0 E116 0 1 0 40000000 1 1 1
I 0 0 6300 0 1 0 40000000 1 1 1
I 0 0 0002 0 1 0 40000000 1 1 1
I 0 0 0010 0 1 0 40000000 1 1 1
I 0 0 A000 1 8 0 40000000 1 1 1
I 0 0 632E 0 1 0 40000000 1 1 1
I 0 0 0000 0 2 0 40000000 1 1 1
X F 3 0 F 000003 000A 1
X C 40000388 0010
X D 7FFE 1 5
I 0 1 C5BC 0 1 0 40000000 1 1 1
I 1 1 5CFB 0 1 0 40000000 1 1 1
I 0 0 EB90 0 1 0 40000000 1 1 1
I 0 0 E116 0 1 0 40000000 1 1 1
I 0 0 CF00 0 1 0 40000000 1 1 1
I 0 0 0003 0 1 0 40000000 1 1 1
I 0 0 000A 0 1 0 40000000 1 1 1
I 0 0 7FFE 1 5 0 40000000 1 1 1
I 0 0 4F0E 0 1 0 40000000 1 1 1
I 0 0 0000 0 2 0 40000000 1 1 1
I 0 0 0000 0 1 1 60000000 1 1 1
I 0 0 0000 0 4 0 60000000 1 1 1
X F 2 3 1 010004 0008 0
X C 60000000 0008
X D 3000 1 4
I 0 1 C5BC 0 1 0 60000000 1 1 1
I 1 1 5CFB 0 1 0 60000000 1 1 1
I 0 0 EB90 0 1 0 60000000 1 1 1
I 0 0 E116 0 1 0 60000000 1 1 1
I 0 0 B101 0 1 0 60000000 1 1 1
I 0 0 0004 0 1 0 60000000 1 1 1
I 0 0 0008 0 1 0 60000000 1 1 1
I 0 0 3000 0 1 0 60000000 1 1 1
I 0 1 3001 0 1 0 60000000 1 0 1
I 0 0 3002 0 1 0 60000000 1 1 1
I 0 1 3003 0 1 0 60000000 1 1 1
I 0 0 7113 0 1 0 60000000 1 1 1
I 0 0 0000 0 2 0 60000000 1 1 1
I 1 1 FFFF 0 3 0 60000000 1 1 1
I 0 0 0000 0 64 0 60000000 1 1 1
I 1 1 FFFF 0 1 0 60000000 1 1 1
I 0 0 0000 0 10 0 60000000 1 1 1
X L 2 1 3

/* verif/tb_rx_link.sv */
//////////////////////////////
// Testbench for rx_link_top, replays verif/rx_link_stim.txt.
// Must be run from the project root so the stimulus path resolves.
// Hold-off is shortened to 64 cycles.
//////////////////////////////
`timescale 1ns/1ps
`include "rx_link_settings.svh"

module tb_rx_link;

    localparam int E_DMA   = 0;
    localparam int E_CMD   = 1;
    localparam int E_FRAME = 2;
    localparam int E_LOSS  = 3;
    localparam int E_OTHER = 4;

    // One replay record, data steps by step for count cycles
    typedef struct packed {
        logic        k_msb;
        logic        k_lsb;
        logic [15:0] data;
        logic [15:0] step;
        logic [15:0] count;
        logic        rx_start;
        logic [31:0] base;
        logic        link_ena;
        logic        sync_ena;
        logic        dma_ready;
    } stim_rec_t;

    logic                        clk;
    logic                        i_rst;
    rx_link_pkg::rx_link_word_t  i_link;
    logic                        i_rx_start;
    logic [31:0]                 i_rx_base_addr;
    logic                        i_link_loss_ena;
    logic                        i_sync_loss_ena;
    logic                        i_wr_cmd_ack;
    logic                        i_dma_wr_ready;
    logic                        o_wr_cmd_req;
    rx_link_pkg::rx_dma_cmd_t    o_wr_cmd;
    logic                        o_dma_wr_valid;
    logic [63:0]                 o_dma_wr_data;
    rx_link_pkg::rx_frame_info_t o_frame_info;
    logic                        o_frame_end;
    logic                        o_checksum_error;
    logic                        o_link_loss;
    logic                        o_sync_loss;
    logic                        o_loss_interrupt;

    stim_rec_t                   stim_q[$];
    logic [63:0]                 dma_q[$];
    rx_link_pkg::rx_dma_cmd_t    cmd_q[$];
    rx_link_pkg::rx_frame_info_t info_q[$];
    logic                        cks_q[$];
    rx_link_pkg::rx_frame_info_t exp_info;
    rx_link_pkg::rx_dma_cmd_t    exp_cmd;
    int                          err_cnt[5];
    int                          exp_link;
    int                          exp_sync;
    int                          exp_irq;
    int                          got_link;
    int                          got_sync;
    int                          got_irq;
    logic                        sync_cause;
    longint                      total_cycles;
    logic                        stim_loaded;

    rx_link_top #(
        .HOLDOFF_CYCLES (64)
    ) uut (
        .clk              (clk),
        .i_rst            (i_rst),
        .i_link           (i_link),
        .i_rx_start       (i_rx_start),
        .i_rx_base_addr   (i_rx_base_addr),
        .i_link_loss_ena  (i_link_loss_ena),
        .i_sync_loss_ena  (i_sync_loss_ena),
        .i_wr_cmd_ack     (i_wr_cmd_ack),
        .o_wr_cmd_req     (o_wr_cmd_req),
        .o_wr_cmd         (o_wr_cmd),
        .i_dma_wr_ready   (i_dma_wr_ready),
        .o_dma_wr_valid   (o_dma_wr_valid),
        .o_dma_wr_data    (o_dma_wr_data),
        .o_frame_info     (o_frame_info),
        .o_frame_end      (o_frame_end),
        .o_checksum_error (o_checksum_error),
        .o_link_loss      (o_link_loss),
        .o_sync_loss      (o_sync_loss),
        .o_loss_interrupt (o_loss_interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic compare_hex(input string name, input logic [63:0] got,
                               input logic [63:0] exp, input int kind);
        assert (got === exp) else begin
            err_cnt[kind]++;
            $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Payload ramp packed four lanes per word, first word lowest
    task automatic queue_dma(input logic [15:0] start, input logic [15:0] step,
                             input int count);
        logic [63:0] word;
        int          lane;
        word = '0;
        lane = 0;
        for (int i = 0; i < count; i++) begin
            word[16*lane +: 16] = start + 16'(i) * step;
            lane++;
            if (lane == 4) begin
                dma_q.push_back(word);
                word = '0;
                lane = 0;
            end
        end
        if (lane != 0) begin
            dma_q.push_back(word);
        end
    endtask

    //////////////////////////////
    // Stimulus file
    //////////////////////////////
    task automatic load_stim();
        int          fd;
        int          n;
        string       line;
        string       kind;
        stim_rec_t   rec;
        rx_link_pkg::rx_frame_info_t info;
        rx_link_pkg::rx_dma_cmd_t    cmd;
        logic [31:0] f0, f1, f2, f3, f4, f5, f6, f7, f8, f9;
        fd = $fopen("verif/rx_link_stim.txt", "r");
        assert (fd != 0) else begin
            err_cnt[E_OTHER]++;
            $display("Could not open the stimulus file");
        end
        while (fd != 0 && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) == "I") begin
                n = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h",
                            f0, f1, f2, f3, f4, f5, f6, f7, f8, f9);
                rec.k_msb     = f0[0];
                rec.k_lsb     = f1[0];
                rec.data      = f2[15:0];
                rec.step      = f3[15:0];
                rec.count     = f4[15:0];
                rec.rx_start  = f5[0];
                rec.base      = f6;
                rec.link_ena  = f7[0];
                rec.sync_ena  = f8[0];
                rec.dma_ready = f9[0];
                stim_q.push_back(rec);
                total_cycles += longint'(f4);
            end else if (n > 1 && line.getc(0) == "X") begin
                n = $sscanf(line, "X %s %h %h %h %h %h %h", kind, f0, f1, f2, f3, f4, f5);
                if (kind == "D") begin
                    queue_dma(f0[15:0], f1[15:0], int'(f2));
                end else if (kind == "C") begin
                    cmd.addr = f0;
                    cmd.bbt  = f1[15:0];
                    cmd_q.push_back(cmd);
                end else if (kind == "F") begin
                    info.file_end  = f0[1:0];
                    info.channel   = f1[1:0];
                    info.data_type = f2[3:0];
                    info.line_num  = f3[23:0];
                    info.byte_len  = f4[15:0];
                    info_q.push_back(info);
                    cks_q.push_back(f5[0]);
                end else if (kind == "L") begin
                    exp_link = int'(f0);
                    exp_sync = int'(f1);
                    exp_irq  = int'(f2);
                end else begin
                    err_cnt[E_OTHER]++;
                    $display("Unknown expectation record in the stimulus file: %s", line);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        assert (dma_q.size() <= `RX_FIFO_DEPTH) else begin
            err_cnt[E_OTHER]++;
            $display("Stimulus expects more DMA words than the FIFO can hold");
        end
    endtask

    //////////////////////////////
    // Monitors
    //////////////////////////////
    always @(posedge clk) begin
        if (!i_rst) begin
            // Words wait in the FIFO while the writer holds ready low
            assert (i_dma_wr_ready || !o_dma_wr_valid) else begin
                err_cnt[E_DMA]++;
                $display("DMA valid high while ready is low at %0t", $time);
            end
            if (o_dma_wr_valid) begin
                assert (dma_q.size() != 0) else begin
                    err_cnt[E_DMA]++;
                    $display("DMA word %h arrived with none expected", o_dma_wr_data);
                end
                if (dma_q.size() != 0) begin
                    compare_hex("o_dma_wr_data", o_dma_wr_data, dma_q.pop_front(), E_DMA);
                end
            end
            if (o_frame_end) begin
                assert (info_q.size() != 0) else begin
                    err_cnt[E_FRAME]++;
                    $display("Frame end seen with no frame expected at %0t", $time);
                end
                if (info_q.size() != 0) begin
                    exp_info = info_q.pop_front();
                    compare_hex("file_end", 64'(o_frame_info.file_end),
                                64'(exp_info.file_end), E_FRAME);
                    compare_hex("channel", 64'(o_frame_info.channel),
                                64'(exp_info.channel), E_FRAME);
                    compare_hex("data_type", 64'(o_frame_info.data_type),
                                64'(exp_info.data_type), E_FRAME);
                    compare_hex("line_num", 64'(o_frame_info.line_num),
                                64'(exp_info.line_num), E_FRAME);
                    compare_hex("byte_len", 64'(o_frame_info.byte_len),
                                64'(exp_info.byte_len), E_FRAME);
                    compare_hex("o_checksum_error", 64'(o_checksum_error),
                                64'(cks_q.pop_front()), E_FRAME);
                end
            end
            // A sync loss pulse needs an enabled K flag one cycle earlier
            assert (!o_sync_loss || sync_cause) else begin
                err_cnt[E_LOSS]++;
                $display("Sync loss pulse without an enabled K flag in the cycle before at %0t",
                         $time);
            end
            sync_cause = i_sync_loss_ena & (i_link.k_msb | i_link.k_lsb);
            got_link += int'(o_link_loss);
            got_sync += int'(o_sync_loss);
            got_irq  += int'(o_loss_interrupt);
        end
    end

    // Ack two cycles after each new request
    initial begin : ack_proc
        forever begin
            @(posedge clk);
            if (!i_rst && o_wr_cmd_req) begin
                assert (cmd_q.size() != 0) else begin
                    err_cnt[E_CMD]++;
                    $display("Command request with no command expected at %0t", $time);
                end
                if (cmd_q.size() != 0) begin
                    exp_cmd = cmd_q.pop_front();
                    compare_hex("o_wr_cmd.addr", 64'(o_wr_cmd.addr), 64'(exp_cmd.addr), E_CMD);
                    compare_hex("o_wr_cmd.bbt", 64'(o_wr_cmd.bbt), 64'(exp_cmd.bbt), E_CMD);
                end
                repeat (2) @(negedge clk);
                i_wr_cmd_ack = 1'b1;
                @(negedge clk);
                i_wr_cmd_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (stim_loaded);
        #(total_cycles * 80 + 4000);
        $display("Timeout: the run did not finish by %0t", $time);
        $display("Done: errors found");
        $finish;
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin : main_proc
        stim_rec_t rec;
        int        total;
        i_rst           = 1'b1;
        i_link          = '0;
        i_rx_start      = 1'b0;
        i_rx_base_addr  = '0;
        i_link_loss_ena = 1'b1;
        i_sync_loss_ena = 1'b1;
        i_wr_cmd_ack    = 1'b0;
        i_dma_wr_ready  = 1'b1;
        sync_cause      = 1'b0;
        stim_loaded     = 1'b0;
        total_cycles    = 0;
        load_stim();
        stim_loaded = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        // Everything quiet straight out of reset
        compare_hex("o_wr_cmd_req", 64'(o_wr_cmd_req), 64'd0, E_OTHER);
        compare_hex("o_dma_wr_valid", 64'(o_dma_wr_valid), 64'd0, E_OTHER);
        compare_hex("o_frame_end", 64'(o_frame_end), 64'd0, E_OTHER);
        compare_hex("o_loss_interrupt", 64'(o_loss_interrupt), 64'd0, E_OTHER);
        i_rst = 1'b0;
        foreach (stim_q[r]) begin
            rec = stim_q[r];
            for (int c = 0; c < int'(rec.count); c++) begin
                i_link.k_msb    = rec.k_msb;
                i_link.k_lsb    = rec.k_lsb;
                i_link.data     = rec.data + 16'(c) * rec.step;
                i_rx_start      = rec.rx_start;
                i_rx_base_addr  = rec.base;
                i_link_loss_ena = rec.link_ena;
                i_sync_loss_ena = rec.sync_ena;
                i_dma_wr_ready  = rec.dma_ready;
                @(negedge clk);
            end
        end
        i_link         = '0;
        i_rx_start     = 1'b0;
        i_dma_wr_ready = 1'b1;
        for (int w = 0; w < 200 && dma_q.size() != 0; w++) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        assert (dma_q.size() == 0 && cmd_q.size() == 0 && info_q.size() == 0) else begin
            err_cnt[E_OTHER]++;
            $display("Expected results never seen: %0d DMA words, %0d commands, %0d frames",
                     dma_q.size(), cmd_q.size(), info_q.size());
        end
        compare_hex("o_link_loss count", 64'(got_link), 64'(exp_link), E_LOSS);
        compare_hex("o_sync_loss count", 64'(got_sync), 64'(exp_sync), E_LOSS);
        compare_hex("o_loss_interrupt count", 64'(got_irq), 64'(exp_irq), E_LOSS);
        total = err_cnt[E_DMA] + err_cnt[E_CMD] + err_cnt[E_FRAME] +
                err_cnt[E_LOSS] + err_cnt[E_OTHER];
        $display("Errors: dma %0d, command %0d, frame %0d, loss %0d, other %0d",
                 err_cnt[E_DMA], err_cnt[E_CMD], err_cnt[E_FRAME],
                 err_cnt[E_LOSS], err_cnt[E_OTHER]);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* verilog/rx_data_fifo.sv */
//////////////////////////////
// Packs payload words four to a 64-bit entry, first word lowest.
// No input back-pressure, words are dropped when full.
//////////////////////////////
`timescale 1ns/1ps
`include "rx_link_settings.svh"

module rx_data_fifo (
    input  logic        clk,
    input  logic        i_rst,
    input  logic        i_pay_valid,
    input  logic [15:0] i_pay_word,
    input  logic        i_frame_end,
    input  logic        i_dma_wr_ready,
    output logic        o_dma_wr_valid,
    output logic [63:0] o_dma_wr_data
);

    localparam int DEPTH = `RX_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    logic [63:0] mem [DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [1:0]  lane_cnt;
    logic [47:0] pack;
    logic [63:0] pad_word;
    logic [63:0] wr_word;
    logic        wr_en;
    logic        empty;
    logic        full;

    //////////////////////////////
    // Lane packing
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (i_rst) begin
            lane_cnt <= 2'd0;
        end else if (i_pay_valid) begin
            lane_cnt <= lane_cnt + 2'd1;
        end else if (i_frame_end) begin
            lane_cnt <= 2'd0;
        end
    end

    // Lane 3 never lands here, it goes straight to memory
    always_ff @(posedge clk) begin
        if (i_pay_valid && lane_cnt != 2'd3) begin
            pack[16*lane_cnt +: 16] <= i_pay_word;
        end
    end

    // Unfilled lanes of a partial group read as zero
    always_comb begin
        pad_word = '0;
        for (int i = 0; i < 3; i++) begin
            if (2'(i) < lane_cnt) begin
                pad_word[16*i +: 16] = pack[16*i +: 16];
            end
        end
    end

    assign wr_en   = (i_pay_valid & (lane_cnt == 2'd3)) |
                     (~i_pay_valid & i_frame_end & (lane_cnt != 2'd0));
    assign wr_word = i_pay_valid ? {i_pay_word, pack} : pad_word;

    //////////////////////////////
    // Circular buffer, FWFT read
    //////////////////////////////
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign o_dma_wr_valid = ~empty & i_dma_wr_ready;
    assign o_dma_wr_data  = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (wr_en && !full) begin
            mem[wr_ptr[AW-1:0]] <= wr_word;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (o_dma_wr_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

/* verilog/rx_frame_parser.sv */
//////////////////////////////
// Frame parser for the TLK2711 RX word stream.
// byte_len must be even and at least 2.
// Checksum is the 16-bit wrapping sum of header and payload.
//////////////////////////////
`timescale 1ns/1ps
`include "rx_link_settings.svh"

module rx_frame_parser (
    input  logic                        clk,
    input  logic                        i_rst,
    input  rx_link_pkg::rx_link_word_t  i_link,
    output logic                        o_hdr_valid,
    output rx_link_pkg::rx_frame_info_t o_frame_info,
    output logic                        o_pay_valid,
    output logic [15:0]                 o_pay_word,
    output logic                        o_frame_end,
    output logic                        o_checksum_error,
    output logic                        o_in_payload
);

    rx_link_pkg::rx_state_e cs;
    rx_link_pkg::rx_state_e ns;

    logic [15:0] prev_data;
    logic [15:0] checksum;
    logic [14:0] data_cnt;
    logic        sync_hit;
    logic        sof_hit;
    logic        head_hit;
    logic        data_last;

    assign sync_hit  = ~i_link.k_msb & i_link.k_lsb & (i_link.data == `RX_SYNC_WORD);
    assign sof_hit   = i_link.k_msb & i_link.k_lsb & (i_link.data == `RX_SOF_WORD);
    // Head spans two words, previous word is the high half
    assign head_hit  = ({prev_data, i_link.data} == `RX_HEAD_FLAG);
    assign data_last = (data_cnt == o_frame_info.byte_len[15:1] - 15'd1);

    assign o_in_payload = cs inside {rx_link_pkg::TYPE, rx_link_pkg::LINE,
                                     rx_link_pkg::LENGTH, rx_link_pkg::DATA,
                                     rx_link_pkg::CHECK};

    //////////////////////////////
    // State machine
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (i_rst) begin
            cs <= rx_link_pkg::IDLE;
        end else begin
            cs <= ns;
        end
    end

    always_comb begin
        ns = cs;
        case (cs)
            rx_link_pkg::IDLE:   if (sync_hit) ns = rx_link_pkg::SYNC;
            rx_link_pkg::SYNC:   if (sof_hit) ns = rx_link_pkg::HEAD;
            rx_link_pkg::HEAD:   if (head_hit) ns = rx_link_pkg::TYPE;
            rx_link_pkg::TYPE:   ns = rx_link_pkg::LINE;
            rx_link_pkg::LINE:   ns = rx_link_pkg::LENGTH;
            rx_link_pkg::LENGTH: ns = rx_link_pkg::DATA;
            rx_link_pkg::DATA:   if (data_last) ns = rx_link_pkg::CHECK;
            rx_link_pkg::CHECK:  ns = rx_link_pkg::END1;
            rx_link_pkg::END1:   ns = rx_link_pkg::END2;
            default:             ns = rx_link_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        prev_data <= i_link.data;
    end

    //////////////////////////////
    // Header capture
    //////////////////////////////
    always_ff @(posedge clk) begin
        case (cs)
            rx_link_pkg::TYPE: begin
                {o_frame_info.file_end, o_frame_info.channel,
                 o_frame_info.data_type, o_frame_info.line_num[23:16]} <= i_link.data;
            end
            rx_link_pkg::LINE:   o_frame_info.line_num[15:0] <= i_link.data;
            rx_link_pkg::LENGTH: o_frame_info.byte_len <= i_link.data;
            default: ;
        endcase
    end

    // Running sum, restarts while waiting for a frame
    always_ff @(posedge clk) begin
        case (cs)
            rx_link_pkg::IDLE, rx_link_pkg::SYNC, rx_link_pkg::HEAD: begin
                checksum <= 16'h0;
            end
            rx_link_pkg::TYPE, rx_link_pkg::LINE,
            rx_link_pkg::LENGTH, rx_link_pkg::DATA: begin
                checksum <= checksum + i_link.data;
            end
            default: ;
        endcase
    end

    //////////////////////////////
    // Strobes and status
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (i_rst) begin
            data_cnt         <= '0;
            o_hdr_valid      <= 1'b0;
            o_pay_valid      <= 1'b0;
            o_frame_end      <= 1'b0;
            o_checksum_error <= 1'b0;
        end else begin
            if (cs == rx_link_pkg::DATA) begin
                data_cnt <= data_cnt + 15'd1;
            end else begin
                data_cnt <= '0;
            end
            o_hdr_valid <= (cs == rx_link_pkg::LENGTH);
            o_pay_valid <= (cs == rx_link_pkg::DATA);
            o_frame_end <= (cs == rx_link_pkg::END1);
            // Error flag stays up until the next head is found
            if (cs == rx_link_pkg::HEAD && head_hit) begin
                o_checksum_error <= 1'b0;
            end else if (cs == rx_link_pkg::CHECK) begin
                o_checksum_error <= (checksum != i_link.data);
            end
        end
    end

    always_ff @(posedge clk) begin
        o_pay_word <= i_link.data;
    end

endmodule

/* verilog/rx_link_pkg.sv */
//////////////////////////////
// Types shared by the RX link blocks.
// Header field widths follow the TLK2711 frame layout.
//////////////////////////////
package rx_link_pkg;

    // Parser states, one per link word position
    typedef enum logic [3:0] {
        IDLE   = 4'd0,
        SYNC   = 4'd1,
        HEAD   = 4'd2,
        TYPE   = 4'd3,
        LINE   = 4'd4,
        LENGTH = 4'd5,
        DATA   = 4'd6,
        CHECK  = 4'd7,
        END1   = 4'd8,
        END2   = 4'd9
    } rx_state_e;

    // One link word with its K-character flags
    typedef struct packed {
        logic        k_msb;
        logic        k_lsb;
        logic [15:0] data;
    } rx_link_word_t;

    // Header fields of one frame
    typedef struct packed {
        logic [1:0]  file_end;
        logic [1:0]  channel;
        logic [3:0]  data_type;
        logic [23:0] line_num;
        logic [15:0] byte_len;
    } rx_frame_info_t;

    // DMA write command, bbt is a multiple of 8
    typedef struct packed {
        logic [31:0] addr;
        logic [15:0] bbt;
    } rx_dma_cmd_t;

endpackage

/* verilog/rx_link_settings.svh */
//////////////////////////////
// Link codes follow the TLK2711 K-character map.
// Hold-off is in clk cycles and must stay below 2**24.
// FIFO depth must be a power of two.
//////////////////////////////
`ifndef RX_LINK_SETTINGS_SVH
`define RX_LINK_SETTINGS_SVH

// Idle sync, D5.6 over K28.5, low K flag only
`define RX_SYNC_WORD     16'hC5BC

// Frame start, K28.2 over K27.7, both K flags
`define RX_SOF_WORD      16'h5CFB

// Frame head, high half arrives first
`define RX_HEAD_FLAG     32'hEB90_E116

// Link loss marker, both K flags set
`define RX_LOSS_WORD     16'hFFFF

`define RX_LOSS_HOLDOFF  10000000

// 64-bit entries
`define RX_FIFO_DEPTH    512

`define RX_RESET_ADDR    32'h5000_0000

`endif

/* verilog/rx_link_top.sv */
//////////////////////////////
// TLK2711 RX link top, one clk domain.
// Link words are expected already aligned to clk.
//////////////////////////////
`timescale 1ns/1ps
`include "rx_link_settings.svh"

module rx_link_top #(
    parameter int HOLDOFF_CYCLES = `RX_LOSS_HOLDOFF
) (
    input  logic                        clk,
    input  logic                        i_rst,
    input  rx_link_pkg::rx_link_word_t  i_link,
    input  logic                        i_rx_start,
    input  logic [31:0]                 i_rx_base_addr,
    input  logic                        i_link_loss_ena,
    input  logic                        i_sync_loss_ena,
    input  logic                        i_wr_cmd_ack,
    output logic                        o_wr_cmd_req,
    output rx_link_pkg::rx_dma_cmd_t    o_wr_cmd,
    input  logic                        i_dma_wr_ready,
    output logic                        o_dma_wr_valid,
    output logic [63:0]                 o_dma_wr_data,
    output rx_link_pkg::rx_frame_info_t o_frame_info,
    output logic                        o_frame_end,
    output logic                        o_checksum_error,
    output logic                        o_link_loss,
    output logic                        o_sync_loss,
    output logic                        o_loss_interrupt
);

    logic        hdr_valid;
    logic        pay_valid;
    logic [15:0] pay_word;
    logic        in_payload;

    rx_frame_parser u_parser (
        .clk              (clk),
        .i_rst            (i_rst),
        .i_link           (i_link),
        .o_hdr_valid      (hdr_valid),
        .o_frame_info     (o_frame_info),
        .o_pay_valid      (pay_valid),
        .o_pay_word       (pay_word),
        .o_frame_end      (o_frame_end),
        .o_checksum_error (o_checksum_error),
        .o_in_payload     (in_payload)
    );

    rx_data_fifo u_fifo (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_pay_valid    (pay_valid),
        .i_pay_word     (pay_word),
        .i_frame_end    (o_frame_end),
        .i_dma_wr_ready (i_dma_wr_ready),
        .o_dma_wr_valid (o_dma_wr_valid),
        .o_dma_wr_data  (o_dma_wr_data)
    );

    rx_wr_cmd u_wr_cmd (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_rx_start     (i_rx_start),
        .i_rx_base_addr (i_rx_base_addr),
        .i_hdr_valid    (hdr_valid),
        .i_frame_info   (o_frame_info),
        .i_frame_end    (o_frame_end),
        .i_wr_cmd_ack   (i_wr_cmd_ack),
        .o_wr_cmd_req   (o_wr_cmd_req),
        .o_wr_cmd       (o_wr_cmd)
    );

    rx_loss_detect #(
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
    ) u_loss (
        .clk              (clk),
        .i_rst            (i_rst),
        .i_link           (i_link),
        .i_in_payload     (in_payload),
        .i_link_loss_ena  (i_link_loss_ena),
        .i_sync_loss_ena  (i_sync_loss_ena),
        .o_link_loss      (o_link_loss),
        .o_sync_loss      (o_sync_loss),
        .o_loss_interrupt (o_loss_interrupt)
    );

endmodule

/* verilog/rx_loss_detect.sv */
//////////////////////////////
// Link loss and sync loss pulses.
// HOLDOFF_CYCLES must be between 1 and 2**24.
//////////////////////////////
`timescale 1ns/1ps
`include "rx_link_settings.svh"

module rx_loss_detect #(
    parameter int HOLDOFF_CYCLES = `RX_LOSS_HOLDOFF
) (
    input  logic                       clk,
    input  logic                       i_rst,
    input  rx_link_pkg::rx_link_word_t i_link,
    input  logic                       i_in_payload,
    input  logic                       i_link_loss_ena,
    input  logic                       i_sync_loss_ena,
    output logic                       o_link_loss,
    output logic                       o_sync_loss,
    output logic                       o_loss_interrupt
);

    localparam logic [23:0] HOLD_LAST = 24'(HOLDOFF_CYCLES - 1);

    // Index 0 is link loss, index 1 is sync loss
    logic [1:0] trig;
    logic [1:0] ena;
    logic [1:0] pulse;

    assign trig[0] = i_link.k_msb & i_link.k_lsb & (i_link.data == `RX_LOSS_WORD);
    // Any K character inside a frame means the link slipped
    assign trig[1] = (i_link.k_msb | i_link.k_lsb) & i_in_payload;
    assign ena     = {i_sync_loss_ena, i_link_loss_ena};

    //////////////////////////////
    // Per-kind pulse and hold-off
    //////////////////////////////
    for (genvar g = 0; g < 2; g++) begin : g_loss
        logic        pulse_q;
        logic        flag_q;
        logic [23:0] timer_q;
        logic        fire;

        assign fire     = trig[g] & ~flag_q;
        assign pulse[g] = pulse_q;

        always_ff @(posedge clk) begin
            if (i_rst || !ena[g]) begin
                pulse_q <= 1'b0;
                flag_q  <= 1'b0;
                timer_q <= '0;
            end else begin
                pulse_q <= fire;
                if (fire) begin
                    flag_q <= 1'b1;
                end else if (timer_q == HOLD_LAST) begin
                    flag_q <= 1'b0;
                end
                if (flag_q && timer_q != HOLD_LAST) begin
                    timer_q <= timer_q + 24'd1;
                end else begin
                    timer_q <= '0;
                end
            end
        end
    end

    assign o_link_loss      = pulse[0];
    assign o_sync_loss      = pulse[1];
    assign o_loss_interrupt = |pulse;

endmodule

/* verilog/rx_wr_cmd.sv */
//////////////////////////////
// One DMA write command per frame.
// A header arriving before the ack overwrites the command.
//////////////////////////////
`timescale 1ns/1ps
`include "rx_link_settings.svh"

module rx_wr_cmd (
    input  logic                        clk,
    input  logic                        i_rst,
    input  logic                        i_rx_start,
    input  logic [31:0]                 i_rx_base_addr,
    input  logic                        i_hdr_valid,
    input  rx_link_pkg::rx_frame_info_t i_frame_info,
    input  logic                        i_frame_end,
    input  logic                        i_wr_cmd_ack,
    output logic                        o_wr_cmd_req,
    output rx_link_pkg::rx_dma_cmd_t    o_wr_cmd
);

    logic [31:0] wr_addr;
    logic        req_q;
    logic [15:0] new_bbt;
    rx_link_pkg::rx_dma_cmd_t cmd_q;

    // Byte count rounded up to whole 64-bit words
    assign new_bbt = {i_frame_info.byte_len[15:3] + 13'(|i_frame_info.byte_len[2:0]), 3'b000};

    // Command is presented in the header cycle, then held
    assign o_wr_cmd_req  = req_q | i_hdr_valid;
    assign o_wr_cmd.addr = i_hdr_valid ? wr_addr : cmd_q.addr;
    assign o_wr_cmd.bbt  = i_hdr_valid ? new_bbt : cmd_q.bbt;

    always_ff @(posedge clk) begin
        if (i_hdr_valid) begin
            cmd_q.addr <= wr_addr;
            cmd_q.bbt  <= new_bbt;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            req_q   <= 1'b0;
            wr_addr <= `RX_RESET_ADDR;
        end else begin
            if (i_hdr_valid) begin
                req_q <= 1'b1;
            end else if (i_wr_cmd_ack) begin
                req_q <= 1'b0;
            end
            if (i_rx_start) begin
                wr_addr <= i_rx_base_addr;
            end else if (i_frame_end) begin
                wr_addr <= wr_addr + {16'h0, cmd_q.bbt};
            end
        end
    end

endmodule
